//--- lc3b_types.sv
package lc3b_types;

typedef logic [15:0] lc3b_word;
typedef logic [2:0]  lc3b_reg;

// opcode field ir[15:12]
typedef enum logic [3:0] {
    op_br   = 4'b0000,
    op_add  = 4'b0001,
    op_ldb  = 4'b0010,
    op_stb  = 4'b0011,
    op_jsr  = 4'b0100,
    op_and  = 4'b0101,
    op_ldr  = 4'b0110,
    op_str  = 4'b0111,
    op_rti  = 4'b1000,
    op_not  = 4'b1001,
    op_ldi  = 4'b1010,
    op_sti  = 4'b1011,
    op_jmp  = 4'b1100,
    op_shf  = 4'b1101,
    op_lea  = 4'b1110,
    op_trap = 4'b1111
} lc3b_opcode;

typedef enum logic [1:0] {
    alu_add,
    alu_and,
    alu_not,
    alu_pass_b
} lc3b_alu_op;

typedef enum logic [1:0] {
    fwd_none,
    fwd_ex_mem,
    fwd_mem_wb
} lc3b_fwd_sel;

// decoded instruction, travels down the pipe with its barrier
typedef struct packed {
    lc3b_opcode opcode;
    lc3b_alu_op alu_op;
    logic       use_imm;
    lc3b_word   imm;
    lc3b_reg    sr1;
    lc3b_reg    sr2;
    lc3b_reg    dest;
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    logic       sets_cc;
    logic       is_branch;
    logic [2:0] nzp;
    logic       valid;
} lc3b_control_word;

typedef struct packed {
    logic if_id_stall;
    logic if_id_flush;
    logic id_ex_stall;
    logic id_ex_flush;
    logic ex_mem_stall;
    logic ex_mem_flush;
    logic mem_wb_stall;
    logic mem_wb_flush;
} lc3b_pipeline_control_word;

// held steady while stb is high, until the one-cycle ack
typedef struct packed {
    logic     stb;
    logic     we;
    lc3b_word addr;
    lc3b_word wdata;
} lc3b_mem_req;

endpackage : lc3b_types

//--- stage_fetch.sv
module stage_fetch import lc3b_types::*; #(
    parameter lc3b_word reset_pc = 16'h0000
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  lc3b_pipeline_control_word pipe_ctrl,
    input  logic                      redirect,
    input  lc3b_word                  redirect_pc,
    output lc3b_mem_req               imem_req,
    input  lc3b_word                  imem_rdata,
    input  logic                      imem_ack,
    output logic                      fetch_wait,
    output lc3b_word                  ir,
    output lc3b_word                  pc,
    output logic                      valid
);

// next instruction address, ahead of req_addr only after a redirect
lc3b_word fetch_pc;
lc3b_word next_pc;
lc3b_word req_addr;
logic     req_stb;
// an abandoned fetch is still waiting for its ack
logic     drop;
logic     accept;

assign fetch_wait = !(imem_ack && !drop);
assign accept     = !fetch_wait && !redirect && !pipe_ctrl.if_id_stall;
assign imem_req   = '{stb: req_stb, we: 1'b0, addr: req_addr, wdata: 16'h0000};

always_comb begin
    next_pc = fetch_pc;
    if (redirect) begin
        next_pc = redirect_pc;
    end else if (accept) begin
        next_pc = fetch_pc + 16'd2;
    end
end

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        fetch_pc <= reset_pc;
        req_addr <= reset_pc;
        req_stb  <= 1'b0;
        drop     <= 1'b0;
    end else begin
        fetch_pc <= next_pc;
        // a new request starts once the previous one is answered
        if (!req_stb || imem_ack) begin
            req_stb  <= 1'b1;
            req_addr <= next_pc;
        end
        if (imem_ack) begin
            drop <= 1'b0;
        end else if (req_stb && redirect) begin
            drop <= 1'b1;
        end
    end
end

// IF/ID barrier, a word refused by a stall is simply fetched again
always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        valid <= 1'b0;
    end else if (pipe_ctrl.if_id_flush) begin
        valid <= 1'b0;
    end else if (accept) begin
        valid <= 1'b1;
    end
end

always_ff @(posedge clk) begin
    if (accept) begin
        ir <= imem_rdata;
        pc <= next_pc;
    end
end

endmodule : stage_fetch

//--- stage_decode.sv
module stage_decode import lc3b_types::*; (
    input  logic                      clk,
    input  logic                      arst_n,
    input  lc3b_pipeline_control_word pipe_ctrl,
    input  lc3b_word                  ir,
    input  lc3b_word                  pc,
    input  logic                      valid,
    input  lc3b_reg                   wb_dest,
    input  lc3b_word                  wb_data,
    input  logic                      wb_load,
    output lc3b_control_word          ctrl,
    output lc3b_word                  pc_out,
    output lc3b_word                  sr1_val,
    output lc3b_word                  sr2_val
);

lc3b_word         regs [8];
lc3b_opcode       opcode;
lc3b_control_word dec;
lc3b_word         rd1;
lc3b_word         rd2;

assign opcode = lc3b_opcode'(ir[15:12]);

always_comb begin
    dec        = '0;
    dec.opcode = opcode;
    dec.alu_op = alu_pass_b;
    dec.dest   = ir[11:9];
    dec.sr1    = ir[8:6];
    dec.sr2    = ir[2:0];
    dec.valid  = valid;
    case (opcode)
        op_add, op_and, op_not: begin
            dec.alu_op    = (opcode == op_add) ? alu_add :
                            (opcode == op_and) ? alu_and : alu_not;
            dec.use_imm   = ir[5];
            dec.imm       = {{11{ir[4]}}, ir[4:0]};
            dec.reg_write = 1'b1;
            dec.sets_cc   = 1'b1;
        end
        op_ldr: begin
            dec.imm       = {{10{ir[5]}}, ir[5:0]};
            dec.reg_write = 1'b1;
            dec.mem_read  = 1'b1;
            dec.sets_cc   = 1'b1;
        end
        op_str: begin
            // source register sits where a destination would
            dec.imm       = {{10{ir[5]}}, ir[5:0]};
            dec.sr2       = ir[11:9];
            dec.mem_write = 1'b1;
        end
        op_br: begin
            dec.imm       = {{7{ir[8]}}, ir[8:0]};
            dec.is_branch = 1'b1;
            dec.nzp       = ir[11:9];
        end
        default: begin
        end
    endcase
end

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        for (int i = 0; i < 8; i++) begin
            regs[i] <= 16'h0000;
        end
    end else if (wb_load) begin
        regs[wb_dest] <= wb_data;
    end
end

// write-through of this cycle's write-back
assign rd1 = (wb_load && wb_dest == dec.sr1) ? wb_data : regs[dec.sr1];
assign rd2 = (wb_load && wb_dest == dec.sr2) ? wb_data : regs[dec.sr2];

// ID/EX barrier
always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        ctrl <= '0;
    end else if (pipe_ctrl.id_ex_flush) begin
        ctrl.valid <= 1'b0;
    end else if (!pipe_ctrl.id_ex_stall) begin
        ctrl <= dec;
    end
end

always_ff @(posedge clk) begin
    if (!pipe_ctrl.id_ex_stall) begin
        pc_out  <= pc;
        sr1_val <= rd1;
        sr2_val <= rd2;
    end else begin
        // a held instruction still picks up older results as they retire
        if (wb_load && wb_dest == ctrl.sr1) begin
            sr1_val <= wb_data;
        end
        if (wb_load && wb_dest == ctrl.sr2) begin
            sr2_val <= wb_data;
        end
    end
end

endmodule : stage_decode

//--- stage_execute.sv
module stage_execute import lc3b_types::*; (
    input  logic                      clk,
    input  logic                      arst_n,
    input  lc3b_pipeline_control_word pipe_ctrl,
    input  lc3b_control_word          ctrl,
    input  lc3b_word                  pc,
    input  lc3b_word                  sr1_val,
    input  lc3b_word                  sr2_val,
    input  lc3b_fwd_sel               fwd_a,
    input  lc3b_fwd_sel               fwd_b,
    input  lc3b_word                  ex_mem_result,
    input  lc3b_word                  mem_wb_result,
    output lc3b_control_word          ctrl_out,
    output lc3b_word                  result,
    output lc3b_word                  store_data,
    output lc3b_word                  target
);

lc3b_word a;
lc3b_word b_reg;
lc3b_word b;
lc3b_word offset;
lc3b_word alu;

function automatic lc3b_word select_operand(
    input lc3b_fwd_sel sel,
    input lc3b_word    reg_val,
    input lc3b_word    ex_mem_val,
    input lc3b_word    mem_wb_val
);
    case (sel)
        fwd_ex_mem: return ex_mem_val;
        fwd_mem_wb: return mem_wb_val;
        default:    return reg_val;
    endcase
endfunction

assign a      = select_operand(fwd_a, sr1_val, ex_mem_result, mem_wb_result);
assign b_reg  = select_operand(fwd_b, sr2_val, ex_mem_result, mem_wb_result);
assign b      = ctrl.use_imm ? ctrl.imm : b_reg;
// word offsets, shifted to a byte offset
assign offset = {ctrl.imm[14:0], 1'b0};

always_comb begin
    case (ctrl.alu_op)
        alu_add: alu = a + b;
        alu_and: alu = a & b;
        alu_not: alu = ~a;
        default: alu = b;
    endcase
    // loads and stores carry their effective address in the result slot
    if (ctrl.mem_read || ctrl.mem_write) begin
        alu = a + offset;
    end
end

// EX/MEM barrier
always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        ctrl_out <= '0;
    end else if (pipe_ctrl.ex_mem_flush) begin
        ctrl_out.valid <= 1'b0;
    end else if (!pipe_ctrl.ex_mem_stall) begin
        ctrl_out <= ctrl;
    end
end

always_ff @(posedge clk) begin
    if (!pipe_ctrl.ex_mem_stall) begin
        result     <= alu;
        store_data <= b_reg;
        target     <= pc + offset;
    end
end

endmodule : stage_execute

//--- stage_memory.sv
module stage_memory import lc3b_types::*; (
    input  logic                      clk,
    input  logic                      arst_n,
    input  lc3b_pipeline_control_word pipe_ctrl,
    input  lc3b_control_word          ctrl,
    input  lc3b_word                  result,
    input  lc3b_word                  store_data,
    input  lc3b_word                  target,
    output lc3b_mem_req               dmem_req,
    input  lc3b_word                  dmem_rdata,
    input  logic                      dmem_ack,
    output logic                      data_wait,
    output logic                      redirect,
    output lc3b_word                  redirect_pc,
    output lc3b_reg                   wb_dest,
    output lc3b_word                  wb_data,
    output logic                      wb_load,
    output lc3b_control_word          wb_ctrl
);

logic       mem_op;
logic [2:0] cc;
logic [2:0] cc_now;

function automatic logic [2:0] cc_of(input lc3b_word value);
    if (value[15]) begin
        return 3'b100;
    end
    return (value == 16'h0000) ? 3'b010 : 3'b001;
endfunction

assign mem_op    = ctrl.valid && (ctrl.mem_read || ctrl.mem_write);
assign data_wait = mem_op && !dmem_ack;
assign dmem_req  = '{stb: mem_op, we: mem_op && ctrl.mem_write, addr: result,
                     wdata: store_data};

// flags seen by a branch include the instruction retiring this cycle
assign cc_now      = (wb_ctrl.valid && wb_ctrl.sets_cc) ? cc_of(wb_data) : cc;
assign redirect    = ctrl.valid && ctrl.is_branch && |(ctrl.nzp & cc_now);
assign redirect_pc = target;

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        cc <= 3'b010;
    end else begin
        cc <= cc_now;
    end
end

// MEM/WB barrier, also the write-back stage
always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        wb_ctrl <= '0;
    end else if (pipe_ctrl.mem_wb_flush) begin
        wb_ctrl.valid <= 1'b0;
    end else if (!pipe_ctrl.mem_wb_stall) begin
        wb_ctrl <= ctrl;
    end
end

always_ff @(posedge clk) begin
    if (!pipe_ctrl.mem_wb_stall) begin
        wb_data <= ctrl.mem_read ? dmem_rdata : result;
    end
end

assign wb_dest = wb_ctrl.dest;
assign wb_load = wb_ctrl.valid && wb_ctrl.reg_write;

endmodule : stage_memory

//--- forwarding_controller.sv
module forwarding_controller import lc3b_types::*; (
    input  lc3b_control_word id_ex,
    input  lc3b_control_word ex_mem,
    input  lc3b_control_word mem_wb,
    output lc3b_fwd_sel      fwd_a,
    output lc3b_fwd_sel      fwd_b,
    output logic             load_use
);

logic uses_a;
logic uses_b;
logic a_ex;
logic a_wb;
logic b_ex;
logic b_wb;

function automatic logic writes(input lc3b_control_word w, input lc3b_reg r);
    return w.valid && w.reg_write && (w.dest == r);
endfunction

assign uses_a = id_ex.valid &&
                (id_ex.opcode inside {op_add, op_and, op_not, op_ldr, op_str});
assign uses_b = id_ex.valid && (id_ex.mem_write ||
                ((id_ex.opcode inside {op_add, op_and}) && !id_ex.use_imm));

assign a_ex = uses_a && writes(ex_mem, id_ex.sr1);
assign a_wb = uses_a && writes(mem_wb, id_ex.sr1);
assign b_ex = uses_b && writes(ex_mem, id_ex.sr2);
assign b_wb = uses_b && writes(mem_wb, id_ex.sr2);

// load data only exists after MEM, so the consumer waits a cycle
assign load_use = ex_mem.mem_read && (a_ex || b_ex);

always_comb begin
    fwd_a = fwd_none;
    fwd_b = fwd_none;
    if (a_ex) begin
        fwd_a = ex_mem.mem_read ? fwd_none : fwd_ex_mem;
    end else if (a_wb) begin
        fwd_a = fwd_mem_wb;
    end
    if (b_ex) begin
        fwd_b = ex_mem.mem_read ? fwd_none : fwd_ex_mem;
    end else if (b_wb) begin
        fwd_b = fwd_mem_wb;
    end
end

endmodule : forwarding_controller

//--- stall_arbiter.sv
module stall_arbiter import lc3b_types::*; (
    input  logic                      fetch_wait,
    input  logic                      data_wait,
    input  logic                      load_use,
    input  logic                      redirect,
    output lc3b_pipeline_control_word pipe_ctrl
);

always_comb begin
    pipe_ctrl = '0;
    if (data_wait) begin
        // data memory busy, whole pipe holds
        pipe_ctrl.if_id_stall  = 1'b1;
        pipe_ctrl.id_ex_stall  = 1'b1;
        pipe_ctrl.ex_mem_stall = 1'b1;
        pipe_ctrl.mem_wb_stall = 1'b1;
    end else if (redirect) begin
        // taken branch in MEM squashes the three younger slots
        pipe_ctrl.if_id_flush  = 1'b1;
        pipe_ctrl.id_ex_flush  = 1'b1;
        pipe_ctrl.ex_mem_flush = 1'b1;
    end else if (load_use) begin
        // hold the consumer and send a bubble ahead of it
        pipe_ctrl.if_id_stall  = 1'b1;
        pipe_ctrl.id_ex_stall  = 1'b1;
        pipe_ctrl.ex_mem_flush = 1'b1;
    end else if (fetch_wait) begin
        pipe_ctrl.if_id_flush  = 1'b1;
    end
end

endmodule : stall_arbiter

//--- cpu.sv
module cpu import lc3b_types::*; #(
    parameter lc3b_word reset_pc = 16'h0000
) (
    input  logic        clk,
    input  logic        arst_n,
    output lc3b_mem_req imem_req,
    input  lc3b_word    imem_rdata,
    input  logic        imem_ack,
    output lc3b_mem_req dmem_req,
    input  lc3b_word    dmem_rdata,
    input  logic        dmem_ack
);

lc3b_pipeline_control_word pipe_ctrl;
logic                      fetch_wait;
logic                      data_wait;
logic                      load_use;
logic                      redirect;
lc3b_word                  redirect_pc;

lc3b_word         if_id_ir;
lc3b_word         if_id_pc;
logic             if_id_valid;
lc3b_control_word id_ex_ctrl;
lc3b_word         id_ex_pc;
lc3b_word         id_ex_sr1;
lc3b_word         id_ex_sr2;
lc3b_control_word ex_mem_ctrl;
lc3b_word         ex_mem_result;
lc3b_word         ex_mem_store;
lc3b_word         ex_mem_target;
lc3b_control_word mem_wb_ctrl;
lc3b_reg          wb_dest;
lc3b_word         wb_data;
logic             wb_load;
lc3b_fwd_sel      fwd_a;
lc3b_fwd_sel      fwd_b;

stall_arbiter stall_arbiter_i (
    .fetch_wait,
    .data_wait,
    .load_use,
    .redirect,
    .pipe_ctrl
);

forwarding_controller forwarding_controller_i (
    .id_ex(id_ex_ctrl),
    .ex_mem(ex_mem_ctrl),
    .mem_wb(mem_wb_ctrl),
    .fwd_a,
    .fwd_b,
    .load_use
);

stage_fetch #(.reset_pc(reset_pc)) stage_fetch_i (
    .clk,
    .arst_n,
    .pipe_ctrl,
    .redirect,
    .redirect_pc,
    .imem_req,
    .imem_rdata,
    .imem_ack,
    .fetch_wait,
    .ir(if_id_ir),
    .pc(if_id_pc),
    .valid(if_id_valid)
);

stage_decode stage_decode_i (
    .clk,
    .arst_n,
    .pipe_ctrl,
    .ir(if_id_ir),
    .pc(if_id_pc),
    .valid(if_id_valid),
    .wb_dest,
    .wb_data,
    .wb_load,
    .ctrl(id_ex_ctrl),
    .pc_out(id_ex_pc),
    .sr1_val(id_ex_sr1),
    .sr2_val(id_ex_sr2)
);

stage_execute stage_execute_i (
    .clk,
    .arst_n,
    .pipe_ctrl,
    .ctrl(id_ex_ctrl),
    .pc(id_ex_pc),
    .sr1_val(id_ex_sr1),
    .sr2_val(id_ex_sr2),
    .fwd_a,
    .fwd_b,
    .ex_mem_result,
    .mem_wb_result(wb_data),
    .ctrl_out(ex_mem_ctrl),
    .result(ex_mem_result),
    .store_data(ex_mem_store),
    .target(ex_mem_target)
);

// write-back lives at the end of the memory stage
stage_memory stage_memory_i (
    .clk,
    .arst_n,
    .pipe_ctrl,
    .ctrl(ex_mem_ctrl),
    .result(ex_mem_result),
    .store_data(ex_mem_store),
    .target(ex_mem_target),
    .dmem_req,
    .dmem_rdata,
    .dmem_ack,
    .data_wait,
    .redirect,
    .redirect_pc,
    .wb_dest,
    .wb_data,
    .wb_load,
    .wb_ctrl(mem_wb_ctrl)
);

endmodule : cpu

//--- tb_memory.sv
module tb_memory import lc3b_types::*; #(
    parameter logic [31:0] seed = 32'h0000_0001
) (
    input  logic        clk,
    input  logic        arst_n,
    input  lc3b_mem_req req,
    output lc3b_word    rdata,
    output logic        ack
);

// word addressed, filled by the testbench top before reset ends
lc3b_word    mem [32768];
logic [31:0] rng_state;
logic        busy;
logic [2:0]  remaining;

function automatic logic [2:0] next_delay();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return 3'(rng_state[17:16]) + 3'd1;
endfunction

initial begin
    ack   = 1'b0;
    rdata = 16'h0000;
end

// responses change on the falling edge, the core samples them on the rising one
always @(negedge clk) begin
    if (!arst_n) begin
        rng_state = seed;
        busy      = 1'b0;
        remaining = 3'd0;
        ack      <= 1'b0;
        rdata    <= 16'h0000;
    end else begin
        ack <= 1'b0;
        // a request still present after an ack is a new one
        if (!busy && req.stb) begin
            busy      = 1'b1;
            remaining = next_delay();
        end
        if (busy) begin
            remaining = remaining - 3'd1;
            if (remaining == 3'd0) begin
                busy = 1'b0;
                if (req.we) begin
                    mem[req.addr[15:1]] = req.wdata;
                end
                rdata <= mem[req.addr[15:1]];
                ack   <= 1'b1;
            end
        end
    end
end

endmodule : tb_memory

//--- tb_cpu.sv
module tb_cpu import lc3b_types::*; ();

localparam lc3b_word    start_pc       = 16'h0200;
localparam int          prog_len       = 200;
localparam int          timeout_cycles = prog_len * 40;
localparam int          drain_cycles   = 50;
localparam logic [31:0] seed           = 32'h8cf1_5b1c;
// last instruction of the program branches to itself
localparam lc3b_word    halt_addr      = start_pc + 16'(2 * (prog_len - 1));

logic        clk;
logic        arst_n;
lc3b_mem_req imem_req;
lc3b_word    imem_rdata;
logic        imem_ack;
lc3b_mem_req dmem_req;
lc3b_word    dmem_rdata;
logic        dmem_ack;

logic [31:0] rng_state;
lc3b_word    prog [prog_len];
lc3b_word    model_mem [32768];
lc3b_word    exp_addr [$];
lc3b_word    exp_data [$];
int          errors;
int          stores_checked;
int          cycles;
logic        halt_seen;

cpu #(.reset_pc(start_pc)) cpu_i (
    .clk,
    .arst_n,
    .imem_req,
    .imem_rdata,
    .imem_ack,
    .dmem_req,
    .dmem_rdata,
    .dmem_ack
);

tb_memory #(.seed(seed ^ 32'h0000_1234)) imem_i (
    .clk,
    .arst_n,
    .req(imem_req),
    .rdata(imem_rdata),
    .ack(imem_ack)
);

tb_memory #(.seed(seed ^ 32'h0000_5678)) dmem_i (
    .clk,
    .arst_n,
    .req(dmem_req),
    .rdata(dmem_rdata),
    .ack(dmem_ack)
);

initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
end

function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
endfunction

function automatic int pick(input int n);
    return int'((next_rand() >> 16) % n);
endfunction

task automatic build_program();
    logic [2:0] dr;
    logic [2:0] src;
    logic [2:0] sr2;
    logic [2:0] last_dest;
    logic [3:0] alu_opcode;
    int         kind;
    int         room;
    last_dest = 3'd0;
    for (int i = 0; i < prog_len - 1; i++) begin
        // R7 is never a destination and stays zero as the data window base
        dr   = 3'(pick(7));
        // lean on the latest result so that neighbours depend on each other
        src  = (pick(2) == 0) ? last_dest : 3'(pick(8));
        sr2  = (pick(2) == 0) ? last_dest : 3'(pick(8));
        kind = pick(10);
        // keep branches away from the end so wrong-path fetches stop short of the halt
        if (kind == 9 && i >= prog_len - 8) begin
            kind = 0;
        end
        if (kind < 5) begin
            alu_opcode = (kind < 2) ? 4'b0001 : (kind < 4) ? 4'b0101 : 4'b1001;
            if (alu_opcode == 4'b1001) begin
                prog[i] = {alu_opcode, dr, src, 6'h3f};
            end else if (pick(2) == 0) begin
                prog[i] = {alu_opcode, dr, src, 1'b1, 5'(pick(32))};
            end else begin
                prog[i] = {alu_opcode, dr, src, 3'b000, sr2};
            end
            last_dest = dr;
        end else if (kind < 7) begin
            prog[i]   = {4'b0110, dr, 3'd7, 6'(pick(64))};
            last_dest = dr;
        end else if (kind < 9) begin
            prog[i] = {4'b0111, src, 3'd7, 6'(pick(64))};
        end else begin
            // forward only so that the target never passes the halt
            room    = prog_len - 2 - i;
            prog[i] = {4'b0000, 3'(pick(8)), 9'(pick((room < 8 ? room : 8) + 1))};
        end
    end
    prog[prog_len - 1] = {4'b0000, 3'b111, 9'h1ff};
endtask

task automatic load_memories();
    for (int w = 0; w < 32768; w++) begin
        model_mem[w]  = 16'(w) ^ 16'h5a5a;
        dmem_i.mem[w] = 16'(w) ^ 16'h5a5a;
        // words outside the program are only fetched on a squashed path
        imem_i.mem[w] = 16'(w) ^ 16'hc3c3;
    end
    for (int i = 0; i < prog_len; i++) begin
        imem_i.mem[int'(start_pc[15:1]) + i] = prog[i];
    end
endtask

// executes the program one instruction at a time and records each store
task automatic run_model();
    int         idx;
    lc3b_word   ir;
    lc3b_word   regs [8];
    lc3b_word   a;
    lc3b_word   b;
    lc3b_word   addr;
    lc3b_word   value;
    logic [2:0] cc;
    logic       writes_reg;
    for (int r = 0; r < 8; r++) begin
        regs[r] = 16'h0000;
    end
    cc  = 3'b010;
    idx = 0;
    while (idx < prog_len - 1) begin
        ir         = prog[idx];
        a          = regs[ir[8:6]];
        b          = ir[5] ? {{11{ir[4]}}, ir[4:0]} : regs[ir[2:0]];
        addr       = a + {{9{ir[5]}}, ir[5:0], 1'b0};
        value      = 16'h0000;
        writes_reg = 1'b1;
        idx++;
        case (ir[15:12])
            4'b0001: value = a + b;
            4'b0101: value = a & b;
            4'b1001: value = ~a;
            4'b0110: value = model_mem[addr[15:1]];
            4'b0111: begin
                writes_reg              = 1'b0;
                model_mem[addr[15:1]] = regs[ir[11:9]];
                exp_addr.push_back(addr);
                exp_data.push_back(regs[ir[11:9]]);
            end
            default: begin
                writes_reg = 1'b0;
                if ((ir[11:9] & cc) != 3'b000) begin
                    idx = idx + $signed(ir[8:0]);
                end
            end
        endcase
        if (writes_reg) begin
            regs[ir[11:9]] = value;
            cc = value[15] ? 3'b100 : (value == 16'h0000) ? 3'b010 : 3'b001;
        end
    end
endtask

task automatic check_store(input lc3b_word addr, input lc3b_word data);
    if (exp_addr.size() == 0) begin
        $display("unexpected store of %h to address %h", data, addr);
        errors++;
    end else begin
        if (addr !== exp_addr[0]) begin
            $display("Fail dmem_req.addr: got %h, expected %h", addr, exp_addr[0]);
            errors++;
        end
        if (data !== exp_data[0]) begin
            $display("Fail dmem_req.wdata: got %h, expected %h", data, exp_data[0]);
            errors++;
        end
        void'(exp_addr.pop_front());
        void'(exp_data.pop_front());
        stores_checked++;
    end
endtask

always @(posedge clk) begin
    if (arst_n) begin
        cycles <= cycles + 1;
        if (dmem_req.stb && dmem_req.we && dmem_ack) begin
            check_store(dmem_req.addr, dmem_req.wdata);
        end
        if (imem_req.stb && imem_req.we !== 1'b0) begin
            $display("Fail imem_req.we: got %h, expected %h", imem_req.we, 1'b0);
            errors++;
        end
        if (imem_req.stb && imem_ack) begin
            if (imem_req.addr == halt_addr) begin
                halt_seen <= 1'b1;
            end else if (halt_seen &&
                         (imem_req.addr < halt_addr || imem_req.addr > halt_addr + 16'd6)) begin
                $display("instruction fetch left the halt loop at address %h", imem_req.addr);
                errors++;
            end
        end
    end
end

initial begin
    arst_n         = 1'b0;
    errors         = 0;
    stores_checked = 0;
    cycles         = 0;
    halt_seen      = 1'b0;
    rng_state      = seed;
    build_program();
    load_memories();
    run_model();
    repeat (16) @(negedge clk);
    arst_n = 1'b1;
    // first cycle out of reset has no request on either port
    @(posedge clk);
    if (imem_req.stb !== 1'b0) begin
        $display("Fail imem_req.stb: got %h, expected %h", imem_req.stb, 1'b0);
        errors++;
    end
    if (dmem_req.stb !== 1'b0) begin
        $display("Fail dmem_req.stb: got %h, expected %h", dmem_req.stb, 1'b0);
        errors++;
    end
    @(negedge clk);
    if (imem_req.stb !== 1'b1) begin
        $display("Fail imem_req.stb: got %h, expected %h", imem_req.stb, 1'b1);
        errors++;
    end
    if (imem_req.addr !== start_pc) begin
        $display("Fail imem_req.addr: got %h, expected %h", imem_req.addr, start_pc);
        errors++;
    end
    while (!halt_seen && cycles < timeout_cycles) begin
        @(posedge clk);
    end
    if (!halt_seen) begin
        $display("instruction fetch did not reach halt address %h within %0d cycles",
                 halt_addr, timeout_cycles);
        errors++;
    end else begin
        // older stores may still be in flight behind the halt fetch
        repeat (drain_cycles) @(posedge clk);
    end
    if (exp_addr.size() != 0) begin
        $display("%0d stores of the reference model never reached data memory",
                 exp_addr.size());
        errors++;
    end
    $display("%0d stores checked, %0d errors", stores_checked, errors);
    if (errors == 0) begin
        $display("Simulation passed");
    end else begin
        $display("Simulation failed");
    end
    $finish;
end

endmodule : tb_cpu

//--- verilog.f
lc3b_types.sv
stage_fetch.sv
stage_decode.sv
stage_execute.sv
stage_memory.sv
forwarding_controller.sv
stall_arbiter.sv
cpu.sv
tb_memory.sv
tb_cpu.sv
